/* rtl/ep_buf_ram.sv */
// Single-port data RAM with byte-lane writes and registered read data
`timescale 1ns/1ns

module ep_buf_ram #(
  parameter int EP_AW = 4
) (
  input  logic                           fifoClk,
  input  logic                           ram_en,
  input  ep_fifo_pkg::ram_req_t          ram_req,
  output logic [ep_fifo_pkg::DATA_W-1:0] ram_rdata
);

  // Four endpoint regions back to back
  localparam int MEM_AW = EP_AW + ep_fifo_pkg::EP_ID_W;
  localparam int DEPTH  = 1 << MEM_AW;

  logic [ep_fifo_pkg::DATA_W-1:0] mem [DEPTH];

  logic [MEM_AW-1:0] adr;

  // Upper address bits stay zero for depths below the full RAM range
  assign adr = ram_req.adr[MEM_AW-1:0];

  always_ff @(posedge fifoClk) begin
    if (ram_en) begin
      if (ram_req.wr) begin
        // Only the enabled byte lanes change
        for (int b = 0; b < ep_fifo_pkg::BE_W; b++) begin
          if (ram_req.be[b]) begin
            mem[adr][8*b +: 8] <= ram_req.data[8*b +: 8];
          end
        end
      end else begin
        ram_rdata <= mem[adr];
      end
    end
  end

endmodule

/* rtl/ep_fifo_pkg.sv */
// Shared widths and packed request and response structs for the endpoint FIFO
package ep_fifo_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Data word carried per strobe
  localparam int DATA_W = 32;

  // One enable bit per data byte
  localparam int BE_W = DATA_W / 8;

  // Endpoint number, four endpoints
  localparam int EP_ID_W = 2;
  localparam int NUM_EP = 1 << EP_ID_W;

  // Shared RAM address, wide enough for the deepest endpoint setting
  localparam int RAM_AW = 8;

  // ----------------------------------------------------------------------
  // Producer side
  // ----------------------------------------------------------------------

  // Write request, 38 bits
  typedef struct packed {
    logic [EP_ID_W-1:0] ep;
    logic [BE_W-1:0]    be;
    logic [DATA_W-1:0]  data;
  } ep_wr_t;

  // ----------------------------------------------------------------------
  // RAM side
  // ----------------------------------------------------------------------

  // One access to the single RAM port, 48 bits
  // For writes, be holds the byte lanes to store
  // For reads, be holds the byte enable returned with the response
  // ep only matters on reads, it tags the response
  typedef struct packed {
    logic               vld;
    logic               wr;
    logic [RAM_AW-1:0]  adr;
    logic [BE_W-1:0]    be;
    logic [DATA_W-1:0]  data;
    logic [EP_ID_W-1:0] ep;
  } ram_req_t;

  // ----------------------------------------------------------------------
  // Consumer side
  // ----------------------------------------------------------------------

  // Read response, 38 bits
  typedef struct packed {
    logic [EP_ID_W-1:0] ep;
    logic [BE_W-1:0]    be;
    logic [DATA_W-1:0]  data;
  } ep_rd_rsp_t;

endpackage

/* rtl/ep_fifo_top.sv */
// Endpoint FIFO top level with pointer blocks, select decode, arbiter and RAM
`timescale 1ns/1ns

module ep_fifo_top #(
  parameter int EP_AW = 4
) (
  input  logic                             fifoClk,
  input  logic                             fifoRstn,
  input  logic                             wr_stb,
  input  ep_fifo_pkg::ep_wr_t              wr_req,
  input  logic                             rd_stb,
  input  logic [ep_fifo_pkg::EP_ID_W-1:0]  rd_ep,
  output logic                             rd_valid,
  output ep_fifo_pkg::ep_rd_rsp_t          rd_rsp,
  output logic [ep_fifo_pkg::NUM_EP-1:0]   ep_empty,
  output logic [ep_fifo_pkg::NUM_EP-1:0]   ep_full,
  output logic [ep_fifo_pkg::NUM_EP-1:0]   ep_almost_full,
  output logic [ep_fifo_pkg::NUM_EP-1:0]   ep_almost_empty
);

  localparam int NUM_EP = ep_fifo_pkg::NUM_EP;

  // One-hot endpoint selects
  logic [NUM_EP-1:0] wr_sel;
  logic [NUM_EP-1:0] rd_sel;

  // Masked per-endpoint returns
  logic [NUM_EP-1:0]               wr_acc_ep;
  logic [NUM_EP-1:0]               rd_acc_ep;
  logic [ep_fifo_pkg::RAM_AW-1:0]  wr_adr_ep [NUM_EP];
  logic [ep_fifo_pkg::RAM_AW-1:0]  rd_adr_ep [NUM_EP];
  logic [ep_fifo_pkg::BE_W-1:0]    rsp_be_ep [NUM_EP];

  // Merged values for the addressed endpoint
  logic [ep_fifo_pkg::RAM_AW-1:0] wr_adr;
  logic [ep_fifo_pkg::RAM_AW-1:0] rd_adr;
  logic [ep_fifo_pkg::BE_W-1:0]   rsp_be;
  logic                           wr_acc;
  logic                           rd_acc;

  ep_fifo_pkg::ram_req_t wr_ram;
  ep_fifo_pkg::ram_req_t rd_ram;
  ep_fifo_pkg::ram_req_t ram_req;
  logic                  ram_en;
  logic [ep_fifo_pkg::DATA_W-1:0] ram_rdata;

  // ----------------------------------------------------------------------
  // Endpoint pointer blocks
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_EP; i++) begin : g_ep
    assign wr_sel[i] = wr_stb & (wr_req.ep == i);
    assign rd_sel[i] = rd_stb & (rd_ep == i);

    // Region i starts at i times the endpoint depth
    ep_ptr_ctl #(
      .EP_AW   (EP_AW),
      .EP_BASE (ep_fifo_pkg::RAM_AW'(i << EP_AW))
    ) u_ep_ptr_ctl (
      .fifoClk      (fifoClk),
      .fifoRstn     (fifoRstn),
      .wr_sel       (wr_sel[i]),
      .rd_sel       (rd_sel[i]),
      .wr_be        (wr_req.be),
      .wr_adr       (wr_adr_ep[i]),
      .rd_adr       (rd_adr_ep[i]),
      .wr_acc       (wr_acc_ep[i]),
      .rd_acc       (rd_acc_ep[i]),
      .empty        (ep_empty[i]),
      .full         (ep_full[i]),
      .almost_full  (ep_almost_full[i]),
      .almost_empty (ep_almost_empty[i]),
      .rsp_be       (rsp_be_ep[i])
    );
  end

  // Unselected blocks return zeros, so an OR picks the addressed one
  always_comb begin
    wr_adr = '0;
    rd_adr = '0;
    rsp_be = '0;
    for (int i = 0; i < NUM_EP; i++) begin
      wr_adr = wr_adr | wr_adr_ep[i];
      rd_adr = rd_adr | rd_adr_ep[i];
      rsp_be = rsp_be | rsp_be_ep[i];
    end
  end

  assign wr_acc = |wr_acc_ep;
  assign rd_acc = |rd_acc_ep;

  // ----------------------------------------------------------------------
  // RAM requests
  // ----------------------------------------------------------------------

  assign wr_ram = '{vld: wr_acc, wr: 1'b1, adr: wr_adr, be: wr_req.be,
                    data: wr_req.data, ep: wr_req.ep};

  // Read carries its response byte enable and endpoint as the tag
  assign rd_ram = '{vld: rd_acc, wr: 1'b0, adr: rd_adr, be: rsp_be,
                    data: '0, ep: rd_ep};

  ep_ram_arb u_ep_ram_arb (
    .fifoClk   (fifoClk),
    .fifoRstn  (fifoRstn),
    .wr_req    (wr_ram),
    .rd_req    (rd_ram),
    .wr_go     (wr_acc),
    .rd_go     (rd_acc),
    .ram_rdata (ram_rdata),
    .ram_req   (ram_req),
    .ram_en    (ram_en),
    .rd_valid  (rd_valid),
    .rd_rsp    (rd_rsp)
  );

  ep_buf_ram #(
    .EP_AW (EP_AW)
  ) u_ep_buf_ram (
    .fifoClk   (fifoClk),
    .ram_en    (ram_en),
    .ram_req   (ram_req),
    .ram_rdata (ram_rdata)
  );

endmodule

/* rtl/ep_ptr_ctl.sv */
// Per-endpoint pointer pair, status flags, last byte enable and RAM addresses
`timescale 1ns/1ns

module ep_ptr_ctl #(
  parameter int EP_AW = 4,
  parameter logic [ep_fifo_pkg::RAM_AW-1:0] EP_BASE = '0
) (
  input  logic                           fifoClk,
  input  logic                           fifoRstn,
  input  logic                           wr_sel,
  input  logic                           rd_sel,
  input  logic [ep_fifo_pkg::BE_W-1:0]   wr_be,
  output logic [ep_fifo_pkg::RAM_AW-1:0] wr_adr,
  output logic [ep_fifo_pkg::RAM_AW-1:0] rd_adr,
  output logic                           wr_acc,
  output logic                           rd_acc,
  output logic                           empty,
  output logic                           full,
  output logic                           almost_full,
  output logic                           almost_empty,
  output logic [ep_fifo_pkg::BE_W-1:0]   rsp_be
);

  // Zero fill from the endpoint offset up to the RAM address
  localparam int PAD_W = ep_fifo_pkg::RAM_AW - EP_AW;

  // Pointers carry a roll-over bit above the offset
  logic [EP_AW:0] wr_ptr;
  logic [EP_AW:0] rd_ptr;
  logic [EP_AW:0] wr_ptr_nxt;
  logic [EP_AW:0] rd_ptr_nxt;

  // Byte enable of the newest accepted write
  logic [ep_fifo_pkg::BE_W-1:0] last_be;

  logic low_eq;
  logic last_entry;

  // ----------------------------------------------------------------------
  // Flags
  // ----------------------------------------------------------------------

  assign wr_ptr_nxt = wr_ptr + 1'b1;
  assign rd_ptr_nxt = rd_ptr + 1'b1;

  assign low_eq = (wr_ptr[EP_AW-1:0] == rd_ptr[EP_AW-1:0]);

  // Same offset, roll-over bits tell full from empty
  assign empty = low_eq & (wr_ptr[EP_AW] == rd_ptr[EP_AW]);
  assign full  = low_eq & (wr_ptr[EP_AW] != rd_ptr[EP_AW]);

  // One more write would fill the endpoint
  assign almost_full = (wr_ptr_nxt[EP_AW-1:0] == rd_ptr[EP_AW-1:0]) &
                       (wr_ptr_nxt[EP_AW] != rd_ptr[EP_AW]);

  // One more read would drain it
  assign almost_empty = (rd_ptr_nxt == wr_ptr);

  // ----------------------------------------------------------------------
  // Accepts and addresses, zero unless this endpoint is selected
  // ----------------------------------------------------------------------

  // Full endpoint drops the write, empty endpoint drops the read
  assign wr_acc = wr_sel & ~full;
  assign rd_acc = rd_sel & ~empty;

  assign wr_adr = {ep_fifo_pkg::RAM_AW{wr_sel}} &
                  (EP_BASE + {{PAD_W{1'b0}}, wr_ptr[EP_AW-1:0]});
  assign rd_adr = {ep_fifo_pkg::RAM_AW{rd_sel}} &
                  (EP_BASE + {{PAD_W{1'b0}}, rd_ptr[EP_AW-1:0]});

  // Read drains the endpoint only if no write lands in the same cycle
  assign last_entry = almost_empty & ~wr_acc;

  // Final entry returns the stored byte enable, any other entry all ones
  assign rsp_be = {ep_fifo_pkg::BE_W{rd_sel}} &
                  (last_entry ? last_be : {ep_fifo_pkg::BE_W{1'b1}});

  // ----------------------------------------------------------------------
  // Pointer update
  // ----------------------------------------------------------------------

  always_ff @(posedge fifoClk or negedge fifoRstn) begin
    if (!fifoRstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_acc) begin
        wr_ptr <= wr_ptr_nxt;
      end
      if (rd_acc) begin
        rd_ptr <= rd_ptr_nxt;
      end
    end
  end

  // Kept for the response that empties the endpoint
  always_ff @(posedge fifoClk or negedge fifoRstn) begin
    if (!fifoRstn) begin
      last_be <= '0;
    end else if (wr_acc) begin
      last_be <= wr_be;
    end
  end

endmodule

/* rtl/ep_ram_arb.sv */
// RAM port arbiter with write priority, one-entry read hold and response tagging
`timescale 1ns/1ns

module ep_ram_arb (
  input  logic                          fifoClk,
  input  logic                          fifoRstn,
  input  ep_fifo_pkg::ram_req_t         wr_req,
  input  ep_fifo_pkg::ram_req_t         rd_req,
  input  logic                          wr_go,
  input  logic                          rd_go,
  input  logic [ep_fifo_pkg::DATA_W-1:0] ram_rdata,
  output ep_fifo_pkg::ram_req_t         ram_req,
  output logic                          ram_en,
  output logic                          rd_valid,
  output ep_fifo_pkg::ep_rd_rsp_t       rd_rsp
);

  // Read parked behind a colliding write
  ep_fifo_pkg::ram_req_t rd_hold;
  logic                  hold_vld;

  logic sel_hold;
  logic sel_new;

  // Tag of the read sitting in the RAM output register
  logic                              rsp_pend;
  logic [ep_fifo_pkg::EP_ID_W-1:0]   rsp_ep;
  logic [ep_fifo_pkg::BE_W-1:0]      rsp_be;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------

  // Write first, then the parked read, then a fresh read
  assign sel_hold = hold_vld & ~wr_go;
  assign sel_new  = rd_go & ~wr_go & ~hold_vld;

  always_comb begin
    if (wr_go) begin
      ram_req = wr_req;
    end else if (sel_hold) begin
      ram_req = rd_hold;
    end else begin
      ram_req = rd_req;
    end
  end

  // Idle cycles leave vld low from the masked read request
  assign ram_en = ram_req.vld;

  // ----------------------------------------------------------------------
  // Hold register
  // ----------------------------------------------------------------------

  always_ff @(posedge fifoClk or negedge fifoRstn) begin
    if (!fifoRstn) begin
      hold_vld <= 1'b0;
    end else if (rd_go && !sel_new) begin
      hold_vld <= 1'b1;
    end else if (sel_hold) begin
      hold_vld <= 1'b0;
    end
  end

  always_ff @(posedge fifoClk) begin
    if (rd_go && !sel_new) begin
      rd_hold <= rd_req;
    end
  end

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------

  // Stage one follows the RAM read register
  // Stage two pairs the tag with the read data
  always_ff @(posedge fifoClk or negedge fifoRstn) begin
    if (!fifoRstn) begin
      rsp_pend <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rsp_pend <= ram_en & ~ram_req.wr;
      rd_valid <= rsp_pend;
    end
  end

  always_ff @(posedge fifoClk) begin
    if (ram_en && !ram_req.wr) begin
      rsp_ep <= ram_req.ep;
      rsp_be <= ram_req.be;
    end
    if (rsp_pend) begin
      rd_rsp.ep   <= rsp_ep;
      rd_rsp.be   <= rsp_be;
      rd_rsp.data <= ram_rdata;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ep_fifo -f sources.f \
  -o tb_ep_fifo > sim.log 2>&1 &&
  ./obj_dir/tb_ep_fifo >> sim.log 2>&1 ||
  { cat sim.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* sim/ep_fifo_checker.sv */
// Checker module comparing read responses and endpoint flags with the model expectations
`timescale 1ns/1ns

module ep_fifo_checker (
  input  logic                             fifoClk,
  input  logic                             fifoRstn,
  input  logic                             chk_en,
  input  logic                             rd_valid,
  input  ep_fifo_pkg::ep_rd_rsp_t          rd_rsp,
  input  logic [ep_fifo_pkg::NUM_EP-1:0]   ep_empty,
  input  logic [ep_fifo_pkg::NUM_EP-1:0]   ep_full,
  input  logic [ep_fifo_pkg::NUM_EP-1:0]   ep_almost_full,
  input  logic [ep_fifo_pkg::NUM_EP-1:0]   ep_almost_empty,
  input  logic                             exp_push,
  input  ep_fifo_pkg::ep_rd_rsp_t          exp_rsp,
  input  logic [ep_fifo_pkg::DATA_W-1:0]   exp_mask,
  input  logic [4*ep_fifo_pkg::NUM_EP-1:0] exp_flags,
  output int                               err_cnt,
  output int                               chk_cnt,
  output int                               pend_cnt
);

  localparam int NUM_EP = ep_fifo_pkg::NUM_EP;

  // Responses still owed by the DUT, oldest first
  ep_fifo_pkg::ep_rd_rsp_t        rsp_q [$];
  // Known bytes of each owed word
  logic [ep_fifo_pkg::DATA_W-1:0] mask_q [$];

  // Flag groups, same lane order as exp_flags
  logic [4*NUM_EP-1:0] flags;
  string               flag_name [4] = '{"ep_empty", "ep_full", "ep_almost_full",
                                         "ep_almost_empty"};

  assign flags = {ep_almost_empty, ep_almost_full, ep_full, ep_empty};

  task automatic compare_hex(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Error: %s expected 0x%h, got 0x%h at %0t ns", name, want, got, $time);
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare on the rising edge, before the DUT registers move
  // ----------------------------------------------------------------------

  always @(posedge fifoClk or negedge fifoRstn) begin : check_proc
    ep_fifo_pkg::ep_rd_rsp_t want;
    logic [31:0]             mask;
    if (!fifoRstn) begin
      err_cnt  = 0;
      chk_cnt  = 0;
      pend_cnt = 0;
      rsp_q.delete();
      mask_q.delete();
    end else if (chk_en) begin
      if (exp_push) begin
        rsp_q.push_back(exp_rsp);
        mask_q.push_back(exp_mask);
      end
      // All four flag vectors, every cycle
      for (int g = 0; g < 4; g++) begin
        compare_hex(flag_name[g], 32'(flags[NUM_EP*g +: NUM_EP]),
                    32'(exp_flags[NUM_EP*g +: NUM_EP]));
      end
      if (rd_valid && rsp_q.size() == 0) begin
        err_cnt++;
        $display("Read response from endpoint %0d arrived with no read outstanding",
                 rd_rsp.ep);
      end else if (rd_valid) begin
        want = rsp_q.pop_front();
        mask = mask_q.pop_front();
        compare_hex("rd_rsp.ep", 32'(rd_rsp.ep), 32'(want.ep));
        compare_hex("rd_rsp.be", 32'(rd_rsp.be), 32'(want.be));
        compare_hex("rd_rsp.data", rd_rsp.data & mask, want.data & mask);
      end
      pend_cnt = rsp_q.size();
    end
  end

endmodule

/* sim/tb_ep_fifo.sv */
// Testbench top with clock, reset, LFSR, stimulus table and endpoint queue model
`timescale 1ns/1ns

module tb_ep_fifo;

  localparam int EP_AW   = 4;
  localparam int DEPTH   = 1 << EP_AW;
  localparam int NUM_EP  = ep_fifo_pkg::NUM_EP;
  localparam int EP_W    = ep_fifo_pkg::EP_ID_W;
  localparam int TIMEOUT = 64;

  // Table operations
  localparam int OP_IDLE  = 0;
  localparam int OP_WR    = 1;
  localparam int OP_RD    = 2;
  localparam int OP_MIX   = 3;
  localparam int OP_DRAIN = 4;
  localparam int OP_WRAP  = 5;

  logic                    fifoClk;
  logic                    fifoRstn;
  logic                    wr_stb;
  ep_fifo_pkg::ep_wr_t     wr_req;
  logic                    rd_stb;
  logic [EP_W-1:0]         rd_ep;
  logic                    rd_valid;
  ep_fifo_pkg::ep_rd_rsp_t rd_rsp;
  logic [NUM_EP-1:0]       ep_empty;
  logic [NUM_EP-1:0]       ep_full;
  logic [NUM_EP-1:0]       ep_almost_full;
  logic [NUM_EP-1:0]       ep_almost_empty;

  // Expectations for the checker
  logic                    chk_en;
  logic                    exp_push;
  ep_fifo_pkg::ep_rd_rsp_t exp_rsp;
  logic [31:0]             exp_mask;
  logic [4*NUM_EP-1:0]     exp_flags;
  int                      err_cnt;
  int                      chk_cnt;
  int                      pend_cnt;

  // Set when read responses never arrived
  logic                    timed_out;

  // Queue model with pointers, last byte enable and a RAM shadow of known bytes
  int          wptr [NUM_EP];
  int          rptr [NUM_EP];
  logic [3:0]  last_be [NUM_EP];
  logic [31:0] shadow [NUM_EP*DEPTH];
  logic [3:0]  known [NUM_EP*DEPTH];
  logic [31:0] lfsr;

  // Stimulus table with name, operation, endpoint and count columns
  string row_name [$];
  int    row_op [$];
  int    row_ep [$];
  int    row_cnt [$];

  always #4 fifoClk = ~fifoClk;

  ep_fifo_top #(.EP_AW(EP_AW)) u_ep_fifo_top (.*);

  ep_fifo_checker u_ep_fifo_checker (.*);

  // ----------------------------------------------------------------------
  // Random bits and model helpers
  // ----------------------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic int ep_count(input int ep);
    return (wptr[ep] - rptr[ep] + 2 * DEPTH) % (2 * DEPTH);
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{be[b]}};
    return m;
  endfunction

  // Flags as they stand during the coming cycle
  function automatic void update_exp_flags();
    int n;
    for (int e = 0; e < NUM_EP; e++) begin
      n = ep_count(e);
      exp_flags[e]            = (n == 0);
      exp_flags[NUM_EP+e]     = (n == DEPTH);
      exp_flags[2*NUM_EP+e]   = (n == DEPTH - 1);
      exp_flags[3*NUM_EP+e]   = (n == 1);
    end
  endfunction

  task automatic add_row(input string name, input int op, input int ep, input int cnt);
    row_name.push_back(name);
    row_op.push_back(op);
    row_ep.push_back(ep);
    row_cnt.push_back(cnt);
  endtask

  // ----------------------------------------------------------------------
  // Cycle drivers that change inputs on the falling edge
  // ----------------------------------------------------------------------

  task automatic idle_cycle();
    @(negedge fifoClk);
    update_exp_flags();
    wr_stb   = 1'b0;
    rd_stb   = 1'b0;
    exp_push = 1'b0;
  endtask

  // One strobe cycle then one quiet cycle
  // A write and a read may collide in the strobe cycle
  task automatic strobe_pair(input logic do_wr, input int w_ep, input logic do_rd,
                             input int r_ep);
    logic [31:0] rnd;
    logic [3:0]  be;
    logic        wr_ok;
    logic        rd_ok;
    int          slot;
    @(negedge fifoClk);
    update_exp_flags();
    take_bits(5, rnd);
    be = rnd[4] ? 4'hf : rnd[3:0];
    take_bits(32, rnd);
    // Full endpoint drops the write and empty endpoint drops the read
    wr_ok    = do_wr && (ep_count(w_ep) != DEPTH);
    rd_ok    = do_rd && (ep_count(r_ep) != 0);
    wr_stb   = do_wr;
    wr_req   = '{ep: EP_W'(w_ep), be: be, data: rnd};
    rd_stb   = do_rd;
    rd_ep    = EP_W'(r_ep);
    exp_push = rd_ok;
    if (rd_ok) begin
      slot         = r_ep * DEPTH + rptr[r_ep] % DEPTH;
      exp_rsp.ep   = EP_W'(r_ep);
      exp_rsp.data = shadow[slot];
      exp_mask     = byte_mask(known[slot]);
      // Taking the final entry returns the newest write's byte enable
      if (ep_count(r_ep) == 1 && !(wr_ok && w_ep == r_ep)) exp_rsp.be = last_be[r_ep];
      else exp_rsp.be = 4'hf;
      rptr[r_ep] = (rptr[r_ep] + 1) % (2 * DEPTH);
    end
    if (wr_ok) begin
      slot = w_ep * DEPTH + wptr[w_ep] % DEPTH;
      for (int b = 0; b < 4; b++) if (be[b]) shadow[slot][8*b +: 8] = rnd[8*b +: 8];
      known[slot]   = known[slot] | be;
      last_be[w_ep] = be;
      wptr[w_ep]    = (wptr[w_ep] + 1) % (2 * DEPTH);
    end
    idle_cycle();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pend_cnt != 0 && n < TIMEOUT) begin
      idle_cycle();
      n++;
    end
    if (pend_cnt != 0) begin
      $display("Timeout: %0d read responses still missing after %0d cycles", pend_cnt, n);
      timed_out = 1'b1;
    end else begin
      // Quiet window long enough for any stray response to show
      for (int i = 0; i < 6; i++) idle_cycle();
    end
  endtask

  task automatic run_row(input int r);
    logic [31:0] rnd;
    case (row_op[r])
      OP_IDLE: for (int i = 0; i < row_cnt[r]; i++) idle_cycle();
      OP_WR:   for (int i = 0; i < row_cnt[r]; i++) strobe_pair(1'b1, row_ep[r], 1'b0, 0);
      OP_RD:   for (int i = 0; i < row_cnt[r]; i++) strobe_pair(1'b0, 0, 1'b1, row_ep[r]);
      OP_MIX: begin
        // 0 write only, 1 read only, 2 and 3 both in one cycle
        for (int i = 0; i < row_cnt[r]; i++) begin
          take_bits(6, rnd);
          strobe_pair(rnd[5:4] != 2'd1, int'(rnd[3:2]), rnd[5:4] != 2'd0, int'(rnd[1:0]));
        end
      end
      OP_DRAIN: begin
        for (int e = 0; e < NUM_EP; e++) begin
          while (ep_count(e) != 0) strobe_pair(1'b0, 0, 1'b1, e);
        end
      end
      OP_WRAP: begin
        for (int i = 0; i < row_cnt[r]; i++) begin
          for (int j = 0; j < DEPTH; j++) strobe_pair(1'b1, row_ep[r], 1'b0, 0);
          for (int j = 0; j < DEPTH; j++) strobe_pair(1'b0, 0, 1'b1, row_ep[r]);
        end
      end
      default: idle_cycle();
    endcase
    wait_drain();
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int err_prev;
    int chk_prev;
    int done_rows;
    fifoClk   = 1'b0;
    fifoRstn  = 1'b0;
    wr_stb    = 1'b0;
    wr_req    = '0;
    rd_stb    = 1'b0;
    rd_ep     = '0;
    chk_en    = 1'b0;
    exp_push  = 1'b0;
    exp_rsp   = '0;
    exp_mask  = '0;
    exp_flags = '0;
    timed_out = 1'b0;
    done_rows = 0;
    lfsr      = 32'h9668_2a7b;
    for (int e = 0; e < NUM_EP; e++) begin
      wptr[e]    = 0;
      rptr[e]    = 0;
      last_be[e] = '0;
    end
    for (int s = 0; s < NUM_EP * DEPTH; s++) begin
      shadow[s] = '0;
      known[s]  = '0;
    end
    add_row("reset_flags", OP_IDLE, 0, 4);
    add_row("order_wr_ep1", OP_WR, 1, 6);
    add_row("order_rd_ep1", OP_RD, 1, 6);
    add_row("fill_ep2", OP_WR, 2, 17);
    add_row("drain_ep2", OP_RD, 2, 16);
    add_row("empty_rd_ep2", OP_RD, 2, 2);
    add_row("empty_rd_ep0", OP_RD, 0, 1);
    add_row("interleave", OP_MIX, 0, 80);
    add_row("drain_all", OP_DRAIN, 0, 0);
    add_row("wrap_ep3", OP_WRAP, 3, 3);
    add_row("wrap_ep0", OP_WRAP, 0, 2);
    repeat (16) @(posedge fifoClk);
    @(negedge fifoClk);
    fifoRstn = 1'b1;
    update_exp_flags();
    chk_en = 1'b1;
    for (int r = 0; r < row_name.size() && !timed_out; r++) begin
      err_prev = err_cnt;
      chk_prev = chk_cnt;
      run_row(r);
      done_rows++;
      $display("test %0d %s: %0d checks, %0d errors", r, row_name[r], chk_cnt - chk_prev,
               err_cnt - err_prev);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", done_rows, chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
rtl/ep_fifo_pkg.sv
rtl/ep_ptr_ctl.sv
rtl/ep_ram_arb.sv
rtl/ep_buf_ram.sv
rtl/ep_fifo_top.sv
sim/ep_fifo_checker.sv
sim/tb_ep_fifo.sv
